// File: source/sdram_pkg.sv
package sdram_pkg;

  // {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    DESL      = 4'b1111,
    NOP       = 4'b0111,
    READ      = 4'b0101,
    WRITE     = 4'b0100,
    ACTIVATE  = 4'b0011,
    PRECHARGE = 4'b0010,
    REFRESH   = 4'b0001,
    MRS       = 4'b0000
  } sdram_cmd_e;

  // one address bus, read according to the command on the pins
  typedef union packed {
    logic [12:0] row;        // activate
    struct packed {
      logic [1:0] rsvd;
      logic       ap;        // A10, auto precharge / all banks
      logic [9:0] col;
    } col_word;              // read, write, precharge
    struct packed {
      logic [5:0] rsvd;      // write burst mode and op mode, all zero
      logic [2:0] cas;
      logic       bt;        // 0 = sequential
      logic [2:0] bl;
    } mode;                  // mode register set
  } sdram_addr_u;

  localparam int unsigned BURST_LEN      = 4;
  localparam int unsigned INIT_REFRESHES = 8;
  localparam int unsigned PRECHARGE_WAIT = 3;
  localparam int unsigned REFRESH_WAIT   = 6;
  localparam int unsigned MODE_WAIT      = 3;

  // cas 2, sequential, burst of 4
  localparam sdram_addr_u MODE_WORD = 13'b000000_010_0_010;

endpackage

// File: source/wb_pkg.sv
package wb_pkg;

  localparam int unsigned WB_DATA_W = 32;
  localparam int unsigned WB_SEL_W  = 4;

  // word address as seen from the bus
  typedef struct packed {
    logic [1:0]  bank;
    logic [12:0] row;
    logic [9:0]  col;
  } wb_adr_t;

endpackage

// File: source/sdram_cmd_if.sv
`timescale 1ns/100ps

// a command proposed for the next pin cycle
interface sdram_cmd_if;

  sdram_pkg::sdram_cmd_e  cmd;
  logic [1:0]             ba;
  sdram_pkg::sdram_addr_u addr;
  logic [3:0]             dqm;

  modport source (
    output cmd, ba, addr, dqm
  );

  modport sink (
    input cmd, ba, addr, dqm
  );

endinterface

// File: source/sdram_init_seq.sv
`timescale 1ns/100ps

module sdram_init_seq #(
  parameter int INIT_DELAY = 20000
) (
  input  logic        clk_i,
  input  logic        rst_i,
  sdram_cmd_if.source init_o,
  output logic        init_done_o
);

  localparam int CNT_W = $clog2(INIT_DELAY + 16); // room for the short waits too
  localparam int REF_W = $clog2(sdram_pkg::INIT_REFRESHES + 1);

  localparam logic [2:0] S_WAIT = 3'd0;
  localparam logic [2:0] S_PRE  = 3'd1;
  localparam logic [2:0] S_REF  = 3'd2;
  localparam logic [2:0] S_MODE = 3'd3;
  localparam logic [2:0] S_DONE = 3'd4;

  logic [2:0]       state_q, state_d;
  logic [CNT_W-1:0] cnt_q, cnt_d;
  logic [REF_W-1:0] nref_q, nref_d;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= S_WAIT;
      cnt_q   <= CNT_W'(INIT_DELAY);
      nref_q  <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      nref_q  <= nref_d;
    end
  end

  always_comb begin
    state_d     = state_q;
    cnt_d       = cnt_q;
    nref_d      = nref_q;
    init_o.cmd  = sdram_pkg::NOP;
    init_o.ba   = '0;
    init_o.addr = '0;
    init_o.dqm  = '1;
    case (state_q)
      S_WAIT, S_PRE: begin
        if (cnt_q != '0) begin
          cnt_d = cnt_q - 1'b1;
        end else if (state_q == S_WAIT) begin
          init_o.cmd              = sdram_pkg::PRECHARGE;
          init_o.addr.col_word.ap = 1'b1; // all banks
          cnt_d                   = CNT_W'(sdram_pkg::PRECHARGE_WAIT);
          state_d                 = S_PRE;
        end else begin
          state_d = S_REF;
        end
      end
      S_REF: begin
        if (cnt_q != '0) begin
          cnt_d = cnt_q - 1'b1;
        end else if (nref_q == REF_W'(sdram_pkg::INIT_REFRESHES)) begin
          init_o.cmd  = sdram_pkg::MRS;
          init_o.addr = sdram_pkg::MODE_WORD;
          cnt_d       = CNT_W'(sdram_pkg::MODE_WAIT);
          state_d     = S_MODE;
        end else begin
          init_o.cmd = sdram_pkg::REFRESH;
          nref_d     = nref_q + 1'b1;
          cnt_d      = CNT_W'(sdram_pkg::REFRESH_WAIT);
        end
      end
      S_MODE: begin
        if (cnt_q != '0) begin
          cnt_d = cnt_q - 1'b1;
        end else begin
          state_d = S_DONE;
        end
      end
      default: ; // done, stays here until reset
    endcase
  end

  assign init_done_o = (state_q == S_DONE);

endmodule

// File: source/sdram_access_fsm.sv
`timescale 1ns/100ps

module sdram_access_fsm (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         init_done_i,
  sdram_cmd_if.source                  acc_o,
  input  logic                         cyc_i,
  input  logic                         stb_i,
  input  logic                         we_i,
  input  wb_pkg::wb_adr_t              adr_i,
  input  logic [wb_pkg::WB_SEL_W-1:0]  sel_i,
  input  logic [wb_pkg::WB_DATA_W-1:0] dat_i,
  output logic [wb_pkg::WB_DATA_W-1:0] dat_o,
  output logic                         ack_o,
  input  logic [wb_pkg::WB_DATA_W-1:0] databus_in_i,
  output logic [wb_pkg::WB_DATA_W-1:0] databus_out_o,
  output logic                         databus_dir_o
);

  localparam int CNT_W  = $clog2(sdram_pkg::REFRESH_WAIT + 1);
  localparam int RD_LAT = 2; // cas latency
  localparam int WR_REC = 3;

  localparam logic [2:0] S_IDLE   = 3'd0;
  localparam logic [2:0] S_REF    = 3'd1;
  localparam logic [2:0] S_ACT    = 3'd2;
  localparam logic [2:0] S_RW     = 3'd3;
  localparam logic [2:0] S_RD_LAT = 3'd4;
  localparam logic [2:0] S_RD     = 3'd5;
  localparam logic [2:0] S_WR     = 3'd6;
  localparam logic [2:0] S_WR_REC = 3'd7;

  logic [2:0]       state_q, state_d;
  logic [CNT_W-1:0] cnt_q, cnt_d;
  logic             req;
  logic             last_beat;

  assign req       = cyc_i & stb_i;
  assign last_beat = (cnt_q == CNT_W'(sdram_pkg::BURST_LEN - 1));

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= S_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  always_comb begin
    state_d    = state_q;
    cnt_d      = cnt_q;
    acc_o.cmd  = sdram_pkg::NOP;
    acc_o.ba   = adr_i.bank;
    acc_o.addr = '0;
    acc_o.dqm  = ~sel_i;
    case (state_q)
      S_IDLE: begin
        acc_o.dqm = '1;
        if (init_done_i && req) begin
          acc_o.cmd      = sdram_pkg::ACTIVATE;
          acc_o.addr.row = adr_i.row; // open row
          state_d        = S_ACT;
        end else if (init_done_i) begin
          acc_o.cmd = sdram_pkg::REFRESH;
          cnt_d     = CNT_W'(sdram_pkg::REFRESH_WAIT);
          state_d   = S_REF;
        end
      end
      S_REF: begin
        acc_o.dqm = '1;
        cnt_d     = cnt_q - 1'b1;
        if (cnt_q == '0) begin
          state_d = S_IDLE;
        end
      end
      S_ACT: state_d = S_RW; // activate to read/write gap
      S_RW: begin
        acc_o.cmd               = we_i ? sdram_pkg::WRITE : sdram_pkg::READ;
        acc_o.addr.col_word.ap  = 1'b1; // auto precharge
        acc_o.addr.col_word.col = adr_i.col;
        cnt_d                   = we_i ? '0 : CNT_W'(RD_LAT - 1);
        state_d                 = we_i ? S_WR : S_RD_LAT;
      end
      S_RD_LAT: begin
        cnt_d = cnt_q - 1'b1;
        if (cnt_q == '0) begin
          cnt_d   = '0; // beat counter starts at zero
          state_d = S_RD;
        end
      end
      S_RD, S_WR: begin
        cnt_d = cnt_q + 1'b1;
        if (last_beat) begin
          cnt_d   = CNT_W'(WR_REC - 1);
          state_d = (state_q == S_WR) ? S_WR_REC : S_IDLE;
        end
      end
      default: begin
        acc_o.dqm = '1;
        cnt_d     = cnt_q - 1'b1;
        if (cnt_q == '0) begin
          state_d = S_IDLE;
        end
      end
    endcase
  end

  assign ack_o         = (state_q == S_RD) || (state_q == S_WR);
  assign databus_dir_o = (state_q == S_WR);
  assign databus_out_o = dat_i;
  assign dat_o         = (state_q == S_RD) ? databus_in_i : '0;

endmodule

// File: source/sdram_cmd_out.sv
`timescale 1ns/100ps

module sdram_cmd_out (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        init_done_i,
  sdram_cmd_if.sink   init_i,
  sdram_cmd_if.sink   acc_i,
  output logic        cs_n_o,
  output logic        ras_n_o,
  output logic        cas_n_o,
  output logic        we_n_o,
  output logic        cke_o,
  output logic [1:0]  ba_o,
  output logic [12:0] addr_o,
  output logic [3:0]  dqm_o
);

  sdram_pkg::sdram_cmd_e cmd_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cmd_q  <= sdram_pkg::NOP;
      ba_o   <= '0;
      addr_o <= '0;
      dqm_o  <= '1;
      cke_o  <= 1'b0;
    end else begin
      cke_o <= 1'b1;
      if (init_done_i) begin // access path owns the bus from here on
        cmd_q  <= acc_i.cmd;
        ba_o   <= acc_i.ba;
        addr_o <= acc_i.addr;
        dqm_o  <= acc_i.dqm;
      end else begin
        cmd_q  <= init_i.cmd;
        ba_o   <= init_i.ba;
        addr_o <= init_i.addr;
        dqm_o  <= init_i.dqm;
      end
    end
  end

  assign {cs_n_o, ras_n_o, cas_n_o, we_n_o} = cmd_q;

endmodule

// File: source/sdram_top.sv
`timescale 1ns/100ps

module sdram_top #(
  parameter int INIT_DELAY = 20000
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         cyc_i,
  input  logic                         stb_i,
  input  logic                         we_i,
  input  wb_pkg::wb_adr_t              adr_i,
  input  logic [wb_pkg::WB_SEL_W-1:0]  sel_i,
  input  logic [wb_pkg::WB_DATA_W-1:0] dat_i,
  output logic [wb_pkg::WB_DATA_W-1:0] dat_o,
  output logic                         ack_o,
  output logic                         cs_n_o,
  output logic                         ras_n_o,
  output logic                         cas_n_o,
  output logic                         we_n_o,
  output logic                         cke_o,
  output logic [1:0]                   ba_o,
  output logic [12:0]                  addr_o,
  output logic [3:0]                   dqm_o,
  input  logic [wb_pkg::WB_DATA_W-1:0] databus_in_i,
  output logic [wb_pkg::WB_DATA_W-1:0] databus_out_o,
  output logic                         databus_dir_o
);

  logic init_done;

  sdram_cmd_if init_bus ();
  sdram_cmd_if acc_bus ();

  sdram_init_seq #(
    .INIT_DELAY(INIT_DELAY)
  ) init0 (
    .clk_i,
    .rst_i,
    .init_o      (init_bus.source),
    .init_done_o (init_done)
  );

  sdram_access_fsm access0 (
    .clk_i,
    .rst_i,
    .init_done_i (init_done),
    .acc_o       (acc_bus.source),
    .cyc_i,
    .stb_i,
    .we_i,
    .adr_i,
    .sel_i,
    .dat_i,
    .dat_o,
    .ack_o,
    .databus_in_i,
    .databus_out_o,
    .databus_dir_o
  );

  sdram_cmd_out cmd_out0 (
    .clk_i,
    .rst_i,
    .init_done_i (init_done),
    .init_i      (init_bus.sink),
    .acc_i       (acc_bus.sink),
    .cs_n_o,
    .ras_n_o,
    .cas_n_o,
    .we_n_o,
    .cke_o,
    .ba_o,
    .addr_o,
    .dqm_o
  );

endmodule

// File: test/sdram_model.sv
`timescale 1ns/100ps

module sdram_model (
  input  logic                   clk_i,
  input  logic                   cke_i,
  input  logic                   cs_n_i,
  input  logic                   ras_n_i,
  input  logic                   cas_n_i,
  input  logic                   we_n_i,
  input  logic [1:0]             ba_i,
  input  sdram_pkg::sdram_addr_u addr_i,
  input  logic [3:0]             dqm_i,
  input  logic [31:0]            dq_i,
  output logic [31:0]            dq_o
);

  logic [31:0] mem [logic [24:0]];
  logic [12:0] open_row [0:3];
  logic [24:0] burst_adr; // bank, row, column of the running burst
  int          rd_left = 0;
  int          wr_left = 0;
  int          ref_n   = 0; // refresh commands seen

  // first commands after power-up, read back by the testbench
  sdram_pkg::sdram_cmd_e  log_cmd [0:9];
  sdram_pkg::sdram_addr_u log_addr [0:9];
  int                     log_n = 0;

  logic [3:0] cmd;
  assign cmd = {cs_n_i, ras_n_i, cas_n_i, we_n_i};

  initial dq_o = '0;

  // sequential burst wraps inside the aligned group of four
  function automatic logic [24:0] beat_adr(logic [24:0] a, int beat);
    return {a[24:2], a[1:0] + 2'(beat)};
  endfunction

  function automatic logic [31:0] read_word(logic [24:0] a);
    if (mem.exists(a)) return mem[a];
    return {a[7:0], a[24:1]} ^ 32'h5a5a_a5a5; // never written
  endfunction

  task automatic write_beat(logic [24:0] a);
    logic [31:0] w;
    w = read_word(a);
    for (int b = 0; b < 4; b++) begin
      if (!dqm_i[b]) w[8*b +: 8] = dq_i[8*b +: 8]; // dqm high masks the byte
    end
    mem[a] = w;
  endtask

  always @(posedge clk_i) begin
    if (rd_left != 0) begin
      dq_o    <= read_word(beat_adr(burst_adr, 4 - rd_left));
      rd_left <= rd_left - 1;
    end
    if (wr_left != 0) begin
      write_beat(beat_adr(burst_adr, 4 - wr_left));
      wr_left <= wr_left - 1;
    end
    if (cke_i && cmd != sdram_pkg::NOP && cmd != sdram_pkg::DESL) begin
      if (log_n < 10) begin
        log_cmd[log_n]  <= sdram_pkg::sdram_cmd_e'(cmd);
        log_addr[log_n] <= addr_i;
        log_n           <= log_n + 1;
      end
      case (cmd)
        sdram_pkg::ACTIVATE: open_row[ba_i] <= addr_i.row;
        sdram_pkg::REFRESH: ref_n <= ref_n + 1;
        sdram_pkg::READ: begin
          burst_adr <= {ba_i, open_row[ba_i], addr_i.col_word.col};
          rd_left   <= 4; // first word out on the next edge, cas 2
        end
        sdram_pkg::WRITE: begin
          write_beat({ba_i, open_row[ba_i], addr_i.col_word.col});
          burst_adr <= {ba_i, open_row[ba_i], addr_i.col_word.col};
          wr_left   <= 3;
        end
        default: ;
      endcase
    end
  end

endmodule

// File: test/sdram_chk.sv
`timescale 1ns/100ps

module sdram_chk (
  input logic       clk_i,
  input logic       rst_i,
  input logic       ack_i,
  input logic       we_i,
  input logic       dir_i,
  input logic       cke_i,
  input logic [3:0] cmd_i
);

  int fails = 0;

  // each burst is four beats
  ack_run: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(ack_i) |-> ack_i [*4] ##1 !ack_i)
    else begin
      $error("ack_o run is not four cycles long");
      fails++;
    end

  // data bus driven in exactly the write beats
  dir_on_write: assert property (@(posedge clk_i) disable iff (rst_i)
    dir_i == (ack_i && we_i))
    else begin
      $error("databus_dir_o does not follow the write beats");
      fails++;
    end

  act_before_rw: assert property (@(posedge clk_i) disable iff (rst_i)
    (cmd_i == sdram_pkg::READ || cmd_i == sdram_pkg::WRITE)
      |-> $past(cmd_i, 2) == sdram_pkg::ACTIVATE)
    else begin
      $error("read or write without activate two cycles before");
      fails++;
    end

  cke_in_reset: assert property (@(posedge clk_i) rst_i |-> !cke_i)
    else begin
      $error("cke high during reset");
      fails++;
    end

endmodule

bind sdram_top sdram_chk chk0 (
  .clk_i,
  .rst_i,
  .ack_i (ack_o),
  .we_i,
  .dir_i (databus_dir_o),
  .cke_i (cke_o),
  .cmd_i ({cs_n_o, ras_n_o, cas_n_o, we_n_o})
);

// File: test/tb_sdram.sv
`timescale 1ns/100ps

module tb_sdram;

  localparam int INIT_DELAY = 200;
  localparam int CLK_PERIOD = 40;
  localparam int N_CASES    = 16;
  localparam int N_COLS     = 8;  // kind, adr, sel, four words, seed flag
  localparam int IDLE_GAP   = 150;
  localparam int ACK_WAIT   = INIT_DELAY + 200;

  logic                         clk = 1'b0;
  logic                         rst;
  logic                         cyc, stb, we, ack;
  wb_pkg::wb_adr_t              adr;
  logic [wb_pkg::WB_SEL_W-1:0]  sel;
  logic [wb_pkg::WB_DATA_W-1:0] dat_w, dat_r, bus_in, bus_out;
  logic                         bus_dir, cs_n, ras_n, cas_n, we_n, cke;
  logic [1:0]                   ba;
  logic [12:0]                  addr;
  logic [3:0]                   dqm;

  logic [31:0] cases [0:N_CASES*N_COLS-1];
  logic [31:0] ref_mem [logic [24:0]];
  int          errors = 0;
  int          passed = 0;
  int          case_errors;
  bit          loaded = 0;

  always #(CLK_PERIOD/2) clk = ~clk;

  sdram_top #(.INIT_DELAY(INIT_DELAY)) dut0 (
    .clk_i(clk), .rst_i(rst),
    .cyc_i(cyc), .stb_i(stb), .we_i(we), .adr_i(adr), .sel_i(sel),
    .dat_i(dat_w), .dat_o(dat_r), .ack_o(ack),
    .cs_n_o(cs_n), .ras_n_o(ras_n), .cas_n_o(cas_n), .we_n_o(we_n), .cke_o(cke),
    .ba_o(ba), .addr_o(addr), .dqm_o(dqm),
    .databus_in_i(bus_in), .databus_out_o(bus_out), .databus_dir_o(bus_dir)
  );

  sdram_model model0 (
    .clk_i(clk), .cke_i(cke),
    .cs_n_i(cs_n), .ras_n_i(ras_n), .cas_n_i(cas_n), .we_n_i(we_n),
    .ba_i(ba), .addr_i(addr), .dqm_i(dqm),
    .dq_i(bus_dir ? bus_out : 'z), // tristate pad on the board
    .dq_o(bus_in)
  );

  task automatic check_word(input logic [wb_pkg::WB_DATA_W-1:0] exp, act,
                            input logic [wb_pkg::WB_SEL_W-1:0] mask, input string what);
    logic [wb_pkg::WB_DATA_W-1:0] m;
    for (int b = 0; b < wb_pkg::WB_SEL_W; b++) m[8*b +: 8] = {8{mask[b]}};
    if ((exp & m) !== (act & m)) begin
      $display("[ERROR] %0t: %s read %h, expected %h", $time, what, act, exp);
      case_errors++;
    end
  endtask

  task automatic check_cmd(input sdram_pkg::sdram_cmd_e exp, act, input string what);
    if (act !== exp) begin
      $display("[ERROR] %0t: %s is %s, expected %s", $time, what, act.name(), exp.name());
      case_errors++;
    end
  endtask

  task automatic check_addr(input sdram_pkg::sdram_addr_u exp, act, input string what);
    if (act !== exp) begin
      $display("[ERROR] %0t: %s address %h, expected %h", $time, what, act, exp);
      case_errors++;
    end
  endtask

  function automatic logic [24:0] beat_key(wb_pkg::wb_adr_t a, int beat);
    logic [1:0] low;
    low = a.col[1:0] + 2'(beat); // sequential order within four
    return {a.bank, a.row, a.col[9:2], low};
  endfunction

  task automatic check_init_order();
    sdram_pkg::sdram_addr_u pre_adr, mode_adr;
    pre_adr             = '0;
    pre_adr.col_word.ap = 1'b1;
    mode_adr            = '0;
    mode_adr.mode.cas   = 3'd2;
    mode_adr.mode.bl    = 3'b010; // burst of 4, sequential
    case_errors         = 0;
    if (model0.log_n < 10) begin
      $display("init order: only %0d commands seen before the first burst", model0.log_n);
      case_errors++;
    end else begin
      check_cmd(sdram_pkg::PRECHARGE, model0.log_cmd[0], "init command 0");
      check_addr(pre_adr, model0.log_addr[0], "init precharge");
      for (int i = 1; i <= 8; i++) begin
        check_cmd(sdram_pkg::REFRESH, model0.log_cmd[i], $sformatf("init command %0d", i));
      end
      check_cmd(sdram_pkg::MRS, model0.log_cmd[9], "init command 9");
      check_addr(mode_adr, model0.log_addr[9], "mode register set");
    end
    $display("init order: %s", (case_errors == 0) ? "ok" : "FAILED");
    errors += case_errors;
    if (case_errors == 0) passed++;
  endtask

  task automatic run_case(input int idx);
    logic [31:0]                  kind, seed;
    logic [wb_pkg::WB_DATA_W-1:0] words [0:3];
    logic [wb_pkg::WB_DATA_W-1:0] exp, m, old;
    logic [24:0]                  key;
    int                           beat, waited, refs;
    kind        = cases[idx*N_COLS];
    seed        = cases[idx*N_COLS+7];
    case_errors = 0;
    for (int i = 0; i < 4; i++) begin
      words[i] = (seed[0] && kind == 1) ? $urandom : cases[idx*N_COLS+3+i];
    end
    if (kind == 2) begin
      refs = model0.ref_n;
      repeat (IDLE_GAP) @(negedge clk); // refreshes run meanwhile
      if (model0.ref_n == refs) begin
        $display("case %0d: no refresh seen during the idle gap", idx);
        case_errors++;
      end
    end
    cyc = 1'b1;
    stb = 1'b1;
    we  = (kind == 1);
    adr = wb_pkg::wb_adr_t'(cases[idx*N_COLS+1][24:0]);
    sel = cases[idx*N_COLS+2][3:0];
    for (int b = 0; b < 4; b++) m[8*b +: 8] = {8{sel[b]}};
    beat   = 0;
    waited = 0;
    while (beat < 4 && waited < ACK_WAIT) begin
      @(negedge clk);
      if (ack) begin
        key = beat_key(adr, beat);
        if (we) begin
          dat_w        = words[beat];
          old          = ref_mem.exists(key) ? ref_mem[key] : '0;
          ref_mem[key] = (old & ~m) | (words[beat] & m);
        end else if (seed[0] && !ref_mem.exists(key)) begin
          $display("case %0d: no earlier write to %h to compare with", idx, key);
          case_errors++;
        end else begin
          exp = seed[0] ? ref_mem[key] : words[beat];
          check_word(exp, dat_r, sel, $sformatf("case %0d beat %0d", idx, beat));
        end
        beat++;
      end else begin
        waited++;
      end
    end
    if (beat < 4) begin
      $display("case %0d: missing acknowledge, %0d of 4 beats seen", idx, beat);
      case_errors++;
    end
    @(negedge clk);
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
    $display("case %0d %s at %h: %s", idx, (kind == 1) ? "write" : "read", adr,
             (case_errors == 0) ? "ok" : "FAILED");
    errors += case_errors;
    if (case_errors == 0) passed++;
  endtask

  initial begin
    void'($urandom(20417));
    rst   = 1'b1;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    sel   = '0;
    dat_w = '0;
    $readmemh("test/sdram_cases.txt", cases);
    loaded = 1'b1;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < N_CASES; i++) begin
      run_case(i);
      if (i == 0) check_init_order(); // first burst closes the init log
    end
    repeat (2) @(negedge clk); // let the bound checker see the last burst close
    errors += dut0.chk0.fails;
    $display("%0d of %0d tests passed, %0d errors, %0d of them from assertions",
             passed, N_CASES + 1, errors, dut0.chk0.fails);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    longint limit;
    wait (loaded);
    limit = INIT_DELAY + 100;
    for (int i = 0; i < N_CASES; i++) begin
      limit += 40 + ((cases[i*N_COLS] == 2) ? IDLE_GAP : 0);
    end
    #(2 * limit * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run did not finish", 2 * limit);
    $display("Test failures found");
    $finish;
  end

endmodule

// File: test/sdram_cases.txt
// kind (0 read, 1 write, 2 read after idle gap), word address, sel,
// four data words (expected words for reads), seed flag (1 = random data)
1 0000400 f 11111111 22222222 33333333 44444444 0
0 0000400 f 11111111 22222222 33333333 44444444 0
1 1800400 f aaaa0001 aaaa0002 aaaa0003 aaaa0004 0
1 0000800 f bbbb0001 bbbb0002 bbbb0003 bbbb0004 0
0 0000400 f 11111111 22222222 33333333 44444444 0
0 1800400 f aaaa0001 aaaa0002 aaaa0003 aaaa0004 0
0 0000800 f bbbb0001 bbbb0002 bbbb0003 bbbb0004 0
1 0000400 5 55667788 99aabbcc ddeeff00 01020304 0
0 0000400 f 11661188 22aa22cc 33ee3300 44024404 0
1 0848c10 f 00000000 00000000 00000000 00000000 1
1 17ffffc f 00000000 00000000 00000000 00000000 1
1 0000800 8 77000000 78000000 79000000 7a000000 0
2 0848c10 f 00000000 00000000 00000000 00000000 1
2 17ffffc f 00000000 00000000 00000000 00000000 1
2 1800400 f aaaa0001 aaaa0002 aaaa0003 aaaa0004 0
2 0000800 f 77bb0001 78bb0002 79bb0003 7abb0004 0

// File: build.f
source/sdram_pkg.sv
source/wb_pkg.sv
source/sdram_cmd_if.sv
source/sdram_init_seq.sv
source/sdram_access_fsm.sv
source/sdram_cmd_out.sv
source/sdram_top.sv
test/sdram_model.sv
test/sdram_chk.sv
test/tb_sdram.sv

// File: Bender.yml
package:
  name: sdram_ctrl

sources:
  - source/sdram_pkg.sv
  - source/wb_pkg.sv
  - source/sdram_cmd_if.sv
  - source/sdram_init_seq.sv
  - source/sdram_access_fsm.sv
  - source/sdram_cmd_out.sv
  - source/sdram_top.sv
  - target: test
    files:
      - test/sdram_model.sv
      - test/sdram_chk.sv
      - test/tb_sdram.sv
